// File: design/link_pkg.sv
package link_pkg;

    ////////////////////
    // Link data
    ////////////////////

    // Three-bit code offered to the slave with valid
    typedef logic [2:0] code_t;

    ////////////////////
    // Master control
    ////////////////////

    // Controller states, in handshake order
    typedef enum logic [1:0] {
        // Waiting for a button press
        IDLE,
        // Request raised, slave has not answered yet
        WAIT_ACK,
        // Ack seen, notice lit while hold time runs
        NOTICE,
        // Code on offer with valid until ack drops
        SEND
    } ctrl_state_e;

    ////////////////////
    // Timing
    ////////////////////

    // One second of the 100 MHz board clock
    localparam int HOLD_CYCLES_BOARD = 100_000_000;

endpackage

// File: design/panel_pkg.sv
package panel_pkg;

    ////////////////////
    // Switch bank
    ////////////////////

    // One-hot switches, one per code value
    localparam int SW_WIDTH = 8;

    ////////////////////
    // Push button
    ////////////////////

    // Samples that must all be high before the press counts
    localparam int DEBOUNCE_DEPTH = 4;

    ////////////////////
    // Seven-segment digit
    ////////////////////

    // Segment lines a..g, bit 0 is a
    localparam int SEG_WIDTH = 7;

    // Active low, so all ones leaves the digit dark
    localparam logic [SEG_WIDTH-1:0] SEG_DARK = '1;

    // Digit shapes indexed by code, bit order gfedcba
    localparam logic [7:0][SEG_WIDTH-1:0] SEG_PATTERN = {
        7'b111_1000,  // 7
        7'b000_0010,  // 6
        7'b001_0010,  // 5
        7'b001_1001,  // 4
        7'b011_0000,  // 3
        7'b010_0100,  // 2
        7'b111_1001,  // 1
        7'b100_0000   // 0
    };

endpackage

// File: design/button_conditioner.sv
`timescale 1ns/10ps

module button_conditioner (
    input  logic clk,
    input  logic rst_n,
    input  logic button,
    output logic press
);
    import panel_pkg::*;

    // Raw button history, newest sample in bit 0
    logic [DEBOUNCE_DEPTH-1:0] samples;
    // Debounced level and its copy one cycle late
    logic level;
    logic level_d;

    // Stable only once every sample agrees
    assign level = &samples;

    ////////////////////
    // Debounce and edge
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Button held through reset must not fire
            samples <= '0;
            level_d <= 1'b0;
            press   <= 1'b0;
        end else begin
            // Shift in the raw button
            samples <= {samples[DEBOUNCE_DEPTH-2:0], button};
            level_d <= level;
            // Single pulse on the rising debounced level
            press   <= level & ~level_d;
        end
    end

endmodule

// File: design/hold_timer.sv
`timescale 1ns/10ps

module hold_timer #(
    parameter int hold_cycles = link_pkg::HOLD_CYCLES_BOARD
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic expired
);
    // Counter just wide enough for the last count
    localparam int CNT_W = (hold_cycles > 1) ? $clog2(hold_cycles) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(hold_cycles - 1);

    logic [CNT_W-1:0] count;

    // High in the final counted cycle only
    assign expired = run && (count == LAST);

    ////////////////////
    // Cycle counter
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run || expired) begin
            // Idle or done, so start over next time
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: design/switch_panel.sv
`timescale 1ns/10ps

module switch_panel (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [panel_pkg::SW_WIDTH-1:0] switches,
    output link_pkg::code_t                code,
    output logic [panel_pkg::SEG_WIDTH-1:0] seg
);
    import link_pkg::*;
    import panel_pkg::*;

    ////////////////////
    // One-hot encoder
    ////////////////////

    // Bit position of the single set switch
    // Zero, idle or several switches, all give code zero
    always_comb begin
        code = '0;
        for (int i = 0; i < SW_WIDTH; i++) begin
            if (switches == (SW_WIDTH'(1) << i)) begin
                code = code_t'(i);
            end
        end
    end

    ////////////////////
    // Display register
    ////////////////////

    // Digit follows the code one edge later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Dark digit while in reset
            seg <= SEG_DARK;
        end else begin
            seg <= SEG_PATTERN[code];
        end
    end

endmodule

// File: design/master_control.sv
`timescale 1ns/10ps

module master_control (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            press,
    input  logic            ack,
    input  link_pkg::code_t code,
    input  logic            expired,
    output logic            run,
    output logic            req,
    output logic            notice,
    output logic            valid,
    output link_pkg::code_t data
);
    import link_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Only a fresh press starts a transfer
                if (press) begin
                    state_nxt = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                // Keep asking until the slave answers
                if (ack) begin
                    state_nxt = NOTICE;
                end
            end
            NOTICE: begin
                // Ack is still high here and gets no attention
                if (expired) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                // Slave withdrew ack, so it has the code
                if (!ack) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    ////////////////////
    // Hold timer control
    ////////////////////

    // Timer runs for exactly the cycles spent in NOTICE
    assign run = (state == NOTICE);

    ////////////////////
    // Registered outputs
    ////////////////////

    // Outputs decoded from the next state
    // so they change on the same edge as the state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            req    <= 1'b0;
            notice <= 1'b0;
            valid  <= 1'b0;
            data   <= '0;
        end else begin
            state  <= state_nxt;

            // First half of the handshake
            req    <= (state_nxt == WAIT_ACK);

            // Lit for the whole hold time
            notice <= (state_nxt == NOTICE);

            // Second half, ends one edge after ack falls
            valid  <= (state_nxt == SEND);

            // Live switch code while on offer, zero otherwise
            if (state_nxt == SEND) begin
                data <= code;
            end else begin
                data <= '0;
            end
        end
    end

endmodule

// File: design/chip2chip_master.sv
`timescale 1ns/10ps

module chip2chip_master #(
    parameter int hold_cycles = link_pkg::HOLD_CYCLES_BOARD
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            button,
    input  logic [panel_pkg::SW_WIDTH-1:0]  switches,
    input  logic                            ack,
    output logic                            req,
    output logic                            notice,
    output logic                            valid,
    output link_pkg::code_t                 data,
    output logic [panel_pkg::SEG_WIDTH-1:0] seg
);
    import link_pkg::*;

    // One cycle per debounced press
    logic  press;
    // Encoded switch code
    code_t code;
    // Hold timer handshake
    logic  run;
    logic  expired;

    ////////////////////
    // Front panel
    ////////////////////

    button_conditioner button_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .button (button),
        .press  (press)
    );

    switch_panel panel_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .switches (switches),
        .code     (code),
        .seg      (seg)
    );

    ////////////////////
    // Link control
    ////////////////////

    // Notice hold time, shortened in simulation
    hold_timer #(
        .hold_cycles (hold_cycles)
    ) timer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .expired (expired)
    );

    master_control control_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .press   (press),
        .ack     (ack),
        .code    (code),
        .expired (expired),
        .run     (run),
        .req     (req),
        .notice  (notice),
        .valid   (valid),
        .data    (data)
    );

endmodule

// File: dv/link_checker.sv
`timescale 1ns/10ps

module link_checker #(
    parameter int hold_cycles = link_pkg::HOLD_CYCLES_BOARD
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            press,
    input logic                            ack,
    input logic                            req,
    input logic                            notice,
    input logic                            valid,
    input link_pkg::code_t                 data,
    input logic [panel_pkg::SEG_WIDTH-1:0] seg
);
    import link_pkg::*;
    import panel_pkg::*;

    // Samples seen with notice high in the current hold
    int notice_len;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            notice_len <= 0;
        end else if (notice) begin
            notice_len <= notice_len + 1;
        end else begin
            notice_len <= 0;
        end
    end

    ////////////////////
    // Reset
    ////////////////////

    // Quiet link and dark digit one edge into reset
    reset_values: assert property (@(posedge clk)
        !rst_n |=> (!req && !notice && !valid && data == '0 && seg == '1))
        else $error("link outputs not at their reset values");

    ////////////////////
    // First half
    ////////////////////

    // Request waits for the slave with no limit
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req && !ack |=> req)
        else $error("req dropped before ack");

    // Ack turns the request into the notice
    req_to_notice: assert property (@(posedge clk) disable iff (!rst_n)
        req && ack |=> !req && notice)
        else $error("req did not hand over to notice on ack");

    // A request only ever follows a debounced press
    req_from_press: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> $past(press))
        else $error("req rose without a press");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(req && valid))
        else $error("req and valid high together");

    ////////////////////
    // Hold and second half
    ////////////////////

    // Exact hold time, valid takes over on the same edge
    notice_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(notice) |-> (notice_len == hold_cycles) && valid)
        else $error("notice length wrong or valid missing after it");

    valid_from_notice: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(valid) |-> $past(notice))
        else $error("valid rose without a notice before it");

    // Back-pressure from the slave
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        valid && ack |=> valid)
        else $error("valid dropped while ack still high");

    valid_drop: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ack |=> !valid && data == '0)
        else $error("valid or data did not clear after ack fell");

    data_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !valid |-> data == '0)
        else $error("data nonzero without valid");

endmodule

bind chip2chip_master link_checker #(
    .hold_cycles (hold_cycles)
) checker_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .press  (press),
    .ack    (ack),
    .req    (req),
    .notice (notice),
    .valid  (valid),
    .data   (data),
    .seg    (seg)
);

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst_n
);
    // 10 ns period, first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over 8 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/10ps

module tb_top;
    import link_pkg::*;
    import panel_pkg::*;

    // Short hold time for simulation
    localparam int HOLD = 12;
    localparam int TRANSFERS = 12;
    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 button;
    logic [SW_WIDTH-1:0]  switches;
    logic                 ack;
    logic                 req;
    logic                 notice;
    logic                 valid;
    code_t                data;
    logic [SEG_WIDTH-1:0] seg;

    // 16-bit Galois LFSR as the random source
    logic [15:0] lfsr_state = 16'd37170;

    tb_clock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    chip2chip_master #(
        .hold_cycles (HOLD)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .button   (button),
        .switches (switches),
        .ack      (ack),
        .req      (req),
        .notice   (notice),
        .valid    (valid),
        .data     (data),
        .seg      (seg)
    );

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        fail_run($sformatf("MISMATCH %s expected %0h actual %0h", test, expected, actual));
    endtask

    ////////////////////
    // Random bits
    ////////////////////

    // Taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // One step per bit taken
    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Index of the only set switch or zero for anything else
    function automatic code_t expected_code(input logic [SW_WIDTH-1:0] sw);
        int    ones;
        code_t pos;
        ones = 0;
        pos  = '0;
        for (int i = 0; i < SW_WIDTH; i++) begin
            if (sw[i]) begin
                ones++;
                pos = code_t'(i);
            end
        end
        return (ones == 1) ? pos : code_t'(0);
    endfunction

    // Lit segments listed as gfedcba, then inverted for the active-low pins
    function automatic logic [SEG_WIDTH-1:0] digit_shape(input code_t c);
        logic [SEG_WIDTH-1:0] lit;
        case (c)
            3'd0:    lit = 7'b011_1111;
            3'd1:    lit = 7'b000_0110;
            3'd2:    lit = 7'b101_1011;
            3'd3:    lit = 7'b100_1111;
            3'd4:    lit = 7'b110_0110;
            3'd5:    lit = 7'b110_1101;
            3'd6:    lit = 7'b111_1101;
            default: lit = 7'b000_0111;
        endcase
        return ~lit;
    endfunction

    task automatic check_display();
        logic [SEG_WIDTH-1:0] exp;
        exp = digit_shape(expected_code(switches));
        assert (seg == exp) else report_mismatch("display", int'(exp), int'(seg));
    endtask

    task automatic check_data();
        code_t exp;
        exp = expected_code(switches);
        assert (data == exp) else report_mismatch("data", int'(exp), int'(data));
    endtask

    ////////////////////
    // Waits
    ////////////////////

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) fail_run("Timeout: reset was never released");
    endtask

    task automatic wait_req();
        int n;
        n = 0;
        while (!req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!req) fail_run("Timeout: req never rose after the button press");
    endtask

    task automatic wait_valid(input logic level, input string what);
        int n;
        n = 0;
        while (valid != level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (valid != level) fail_run({"Timeout: ", what});
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Mostly one-hot with a raw byte one time in eight
    task automatic pick_switches();
        int sel;
        int raw;
        take_bits(3, sel);
        if (sel == 0) begin
            take_bits(SW_WIDTH, raw);
            switches = SW_WIDTH'(raw);
        end else begin
            take_bits(3, raw);
            switches = SW_WIDTH'(1) << raw;
        end
    endtask

    // Press lasting 4 to 20 cycles
    task automatic hold_button();
        int len;
        take_bits(5, len);
        len = 4 + len % 17;
        button = 1'b1;
        repeat (len) @(negedge clk);
        button = 1'b0;
    endtask

    // Slave side of one four-phase transfer
    task automatic serve_transfer();
        int delay;
        int hold;
        int change;
        wait_req();
        take_bits(3, delay);
        repeat (delay) @(negedge clk);
        ack = 1'b1;
        wait_valid(1'b1, "valid never rose after ack");
        take_bits(3, hold);
        // Switches may move while the code is on offer
        repeat (hold) begin
            check_data();
            check_display();
            take_bits(1, change);
            if (change != 0) pick_switches();
            @(negedge clk);
        end
        check_data();
        check_display();
        ack = 1'b0;
        wait_valid(1'b0, "valid stayed high after ack fell");
        assert (data == '0) else report_mismatch("data_clear", 0, int'(data));
    endtask

    initial begin
        button   = 1'b0;
        switches = '0;
        ack      = 1'b0;
        wait_reset();
        repeat (2) @(negedge clk);
        for (int t = 0; t < TRANSFERS; t++) begin
            pick_switches();
            @(negedge clk);
            check_display();
            fork
                hold_button();
                serve_transfer();
            join
            // Quiet gap with the button released
            repeat (3) begin
                @(negedge clk);
                assert (!req && !notice && !valid)
                    else fail_run("link became active without a button press");
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: list.f
design/link_pkg.sv
design/panel_pkg.sv
design/button_conditioner.sv
design/hold_timer.sv
design/switch_panel.sv
design/master_control.sv
design/chip2chip_master.sv
dv/link_checker.sv
dv/tb_clock.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the chip-to-chip master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_top \
    --Mdir obj_dir \
    -o tb_top_sim \
    -f list.f

./obj_dir/tb_top_sim
